/* rtl/id_pkg.sv */
package id_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths.
    ////////////////////////////////////////////////////////////////////////////

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 2 ** REG_ADDR_W;
    localparam int IMM_W      = 16;
    localparam int JIDX_W     = 26;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [JIDX_W-1:0]     jidx_t;
    typedef logic [FUNCT_W-1:0]    funct_t;
    typedef logic [1:0]            alu_op_t;

    // Link register used by JAL.
    localparam reg_addr_t RA_REG = 5'd31;

    // ALU operation classes handed to the execute stage.
    localparam alu_op_t ALU_OP_ADD   = 2'b00;
    localparam alu_op_t ALU_OP_SUB   = 2'b01;
    localparam alu_op_t ALU_OP_FUNCT = 2'b10;
    localparam alu_op_t ALU_OP_IMM   = 2'b11;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings.
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    // R-type funct codes that change the flow.
    localparam funct_t FUNCT_JR   = 6'h08;
    localparam funct_t FUNCT_JALR = 6'h09;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_J    = 3'd3,
        BR_JAL  = 3'd4,
        BR_JR   = 3'd5,
        BR_JALR = 3'd6
    } branch_e;

endpackage

/* rtl/id_decoder.sv */
`timescale 1ns/100ps

module id_decoder (
    input  id_pkg::word_t     i_instruction,

    output id_pkg::reg_addr_t o_rs,
    output id_pkg::reg_addr_t o_rt,
    output id_pkg::reg_addr_t o_rw,
    output id_pkg::imm_t      o_imm,
    output id_pkg::jidx_t     o_jidx,
    output id_pkg::branch_e   o_branch
);

    ////////////////////////////////////////////////////////////////////////////
    // Field slicing.
    ////////////////////////////////////////////////////////////////////////////

    id_pkg::opcode_e   opcode;
    id_pkg::funct_t    funct;
    id_pkg::reg_addr_t rt;
    id_pkg::reg_addr_t rd;

    assign opcode = id_pkg::opcode_e'(i_instruction[31:26]);
    assign funct  = i_instruction[5:0];
    assign rt     = i_instruction[20:16];
    assign rd     = i_instruction[15:11];

    assign o_rs   = i_instruction[25:21];
    assign o_rt   = rt;
    assign o_imm  = i_instruction[15:0];
    assign o_jidx = i_instruction[25:0];

    ////////////////////////////////////////////////////////////////////////////
    // Destination and branch kind.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Immediate forms write rt.
        o_rw     = rt;
        o_branch = id_pkg::BR_NONE;

        case (opcode)
            id_pkg::OP_RTYPE: begin
                o_rw = rd;
                if (funct == id_pkg::FUNCT_JR) begin
                    o_branch = id_pkg::BR_JR;
                end else if (funct == id_pkg::FUNCT_JALR) begin
                    o_branch = id_pkg::BR_JALR;
                end
            end
            id_pkg::OP_J: begin
                o_branch = id_pkg::BR_J;
            end
            id_pkg::OP_JAL: begin
                // Return address goes to the link register.
                o_rw     = id_pkg::RA_REG;
                o_branch = id_pkg::BR_JAL;
            end
            id_pkg::OP_BEQ: begin
                o_branch = id_pkg::BR_BEQ;
            end
            id_pkg::OP_BNE: begin
                o_branch = id_pkg::BR_BNE;
            end
            default: begin
                o_branch = id_pkg::BR_NONE;
            end
        endcase
    end

endmodule

/* rtl/id_control.sv */
`timescale 1ns/100ps

module id_control (
    input  id_pkg::word_t   i_instruction,

    output logic            o_reg_dst,
    output logic            o_reg_write,
    output logic            o_alu_src,
    output id_pkg::alu_op_t o_alu_op,
    output logic            o_mem_read,
    output logic            o_mem_write,
    output logic            o_mem_to_reg
);

    id_pkg::opcode_e opcode;
    id_pkg::funct_t  funct;

    assign opcode = id_pkg::opcode_e'(i_instruction[31:26]);
    assign funct  = i_instruction[5:0];

    ////////////////////////////////////////////////////////////////////////////
    // Main control table.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Everything off unless the opcode says otherwise.
        o_reg_dst    = 1'b0;
        o_reg_write  = 1'b0;
        o_alu_src    = 1'b0;
        o_alu_op     = id_pkg::ALU_OP_ADD;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_mem_to_reg = 1'b0;

        case (opcode)
            id_pkg::OP_RTYPE: begin
                o_reg_dst   = 1'b1;
                // JR only redirects the PC.
                o_reg_write = (funct != id_pkg::FUNCT_JR);
                o_alu_op    = id_pkg::ALU_OP_FUNCT;
            end
            id_pkg::OP_LW: begin
                o_alu_src    = 1'b1;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
                o_alu_op     = id_pkg::ALU_OP_ADD;
            end
            id_pkg::OP_SW: begin
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
                o_alu_op    = id_pkg::ALU_OP_ADD;
            end
            id_pkg::OP_BEQ,
            id_pkg::OP_BNE: begin
                // Compare by subtraction in the ALU.
                o_alu_op = id_pkg::ALU_OP_SUB;
            end
            id_pkg::OP_ADDI,
            id_pkg::OP_SLTI,
            id_pkg::OP_ANDI,
            id_pkg::OP_ORI,
            id_pkg::OP_LUI: begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
                o_alu_op    = id_pkg::ALU_OP_IMM;
            end
            id_pkg::OP_JAL: begin
                o_reg_write = 1'b1;
            end
            id_pkg::OP_J: begin
                o_reg_write = 1'b0;
            end
            default: begin
                // Unknown opcode acts as a bubble.
                o_reg_write = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/id_register_file.sv */
`timescale 1ns/100ps

module id_register_file (
    input  logic              i_clock,
    input  logic              i_rst_n,

    input  id_pkg::reg_addr_t i_rd_addr_a,
    input  id_pkg::reg_addr_t i_rd_addr_b,

    input  logic              i_we,
    input  id_pkg::reg_addr_t i_wr_addr,
    input  id_pkg::word_t     i_wr_data,

    output id_pkg::word_t     o_rd_data_a,
    output id_pkg::word_t     o_rd_data_b
);

    id_pkg::word_t regs [id_pkg::REG_COUNT];

    ////////////////////////////////////////////////////////////////////////////
    // Write port.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < id_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            // Register zero is never written.
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read ports without write bypass.
    ////////////////////////////////////////////////////////////////////////////

    assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 : regs[i_rd_addr_b];

endmodule

/* rtl/id_branch_unit.sv */
`timescale 1ns/100ps

module id_branch_unit #(
    parameter int PC_W = 11
) (
    input  id_pkg::branch_e i_branch,
    input  logic [PC_W-1:0] i_pc_next,
    input  id_pkg::word_t   i_imm_ext,
    input  id_pkg::jidx_t   i_jidx,
    input  id_pkg::word_t   i_data_a,
    input  id_pkg::word_t   i_data_b,

    output logic            o_taken,
    output logic [PC_W-1:0] o_target
);

    logic            operands_equal;
    logic [PC_W-1:0] branch_target;

    assign operands_equal = (i_data_a == i_data_b);

    // Word offset wraps in the PC width.
    assign branch_target = i_pc_next + i_imm_ext[PC_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Taken flag and target.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        o_taken  = 1'b0;
        o_target = i_pc_next;

        case (i_branch)
            id_pkg::BR_BEQ: begin
                o_taken  = operands_equal;
                o_target = branch_target;
            end
            id_pkg::BR_BNE: begin
                o_taken  = !operands_equal;
                o_target = branch_target;
            end
            id_pkg::BR_J,
            id_pkg::BR_JAL: begin
                o_taken  = 1'b1;
                o_target = i_jidx[PC_W-1:0];
            end
            id_pkg::BR_JR,
            id_pkg::BR_JALR: begin
                // Register jumps take the target from rs.
                o_taken  = 1'b1;
                o_target = i_data_a[PC_W-1:0];
            end
            default: begin
                o_taken  = 1'b0;
                o_target = i_pc_next;
            end
        endcase
    end

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/100ps

module id_stage #(
    parameter int PC_W = 11
) (
    input  logic              i_clock,
    input  logic              i_rst_n,

    input  id_pkg::word_t     i_instruction,
    input  logic [PC_W-1:0]   i_pc_next,

    // Write-back port.
    input  logic              i_wb_we,
    input  id_pkg::reg_addr_t i_wb_addr,
    input  id_pkg::word_t     i_wb_data,

    // Operands for execute.
    output id_pkg::word_t     o_data_a,
    output id_pkg::word_t     o_data_b,
    output id_pkg::word_t     o_imm_ext,
    output id_pkg::reg_addr_t o_rs,
    output id_pkg::reg_addr_t o_rt,
    output id_pkg::reg_addr_t o_rw,

    // Flow change.
    output id_pkg::branch_e   o_branch,
    output logic              o_branch_taken,
    output logic [PC_W-1:0]   o_branch_target,

    // Control.
    output logic              o_reg_dst,
    output logic              o_reg_write,
    output logic              o_alu_src,
    output id_pkg::alu_op_t   o_alu_op,
    output logic              o_mem_read,
    output logic              o_mem_write,
    output logic              o_mem_to_reg
);

    id_pkg::imm_t  imm;
    id_pkg::jidx_t jidx;

    ////////////////////////////////////////////////////////////////////////////
    // Decode.
    ////////////////////////////////////////////////////////////////////////////

    id_decoder decoder_inst (
        .i_instruction (i_instruction),
        .o_rs          (o_rs),
        .o_rt          (o_rt),
        .o_rw          (o_rw),
        .o_imm         (imm),
        .o_jidx        (jidx),
        .o_branch      (o_branch)
    );

    id_control control_inst (
        .i_instruction (i_instruction),
        .o_reg_dst     (o_reg_dst),
        .o_reg_write   (o_reg_write),
        .o_alu_src     (o_alu_src),
        .o_alu_op      (o_alu_op),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_mem_to_reg  (o_mem_to_reg)
    );

    // Sign extension.
    assign o_imm_ext = {{(id_pkg::WORD_W - id_pkg::IMM_W){imm[id_pkg::IMM_W-1]}}, imm};

    ////////////////////////////////////////////////////////////////////////////
    // Operands and branch resolution.
    ////////////////////////////////////////////////////////////////////////////

    id_register_file register_file_inst (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_a (o_rs),
        .i_rd_addr_b (o_rt),
        .i_we        (i_wb_we),
        .i_wr_addr   (i_wb_addr),
        .i_wr_data   (i_wb_data),
        .o_rd_data_a (o_data_a),
        .o_rd_data_b (o_data_b)
    );

    id_branch_unit #(
        .PC_W (PC_W)
    ) branch_unit_inst (
        .i_branch  (o_branch),
        .i_pc_next (i_pc_next),
        .i_imm_ext (o_imm_ext),
        .i_jidx    (jidx),
        .i_data_a  (o_data_a),
        .i_data_b  (o_data_b),
        .o_taken   (o_branch_taken),
        .o_target  (o_branch_target)
    );

endmodule

/* verification/tb_id_stage.sv */
`timescale 1ns/100ps

module tb_id_stage;

    localparam int PC_W           = 11;
    localparam int CLK_PERIOD     = 10;
    localparam int SETTLE         = 2;
    localparam int RESET_CYCLES   = 4;
    localparam int TABLE_LEN      = 19;
    // Reset reads plus a write and a read per register.
    localparam int PRELOAD_CYCLES = 3 * id_pkg::REG_COUNT + 1;
    localparam int MAX_CYCLES     = RESET_CYCLES + PRELOAD_CYCLES + TABLE_LEN + 50;

    // Control order is {reg_dst, reg_write, alu_src, alu_op, mem_read, mem_write, mem_to_reg}.
    localparam logic [7:0] CTRL_RTYPE = 8'b1_1_0_10_0_0_0;
    localparam logic [7:0] CTRL_JR    = 8'b1_0_0_10_0_0_0;
    localparam logic [7:0] CTRL_LW    = 8'b0_1_1_00_1_0_1;
    localparam logic [7:0] CTRL_SW    = 8'b0_0_1_00_0_1_0;
    localparam logic [7:0] CTRL_BR    = 8'b0_0_0_01_0_0_0;
    localparam logic [7:0] CTRL_IMM   = 8'b0_1_1_11_0_0_0;
    localparam logic [7:0] CTRL_JAL   = 8'b0_1_0_00_0_0_0;
    localparam logic [7:0] CTRL_NONE  = 8'b0_0_0_00_0_0_0;

    typedef struct packed {
        id_pkg::word_t     instr;
        logic [PC_W-1:0]   pc_next;
        id_pkg::branch_e   branch;
        logic              taken;
        logic [7:0]        ctrl;
        id_pkg::reg_addr_t rw;
    } vector_t;

    logic              i_clock;
    logic              i_rst_n;
    id_pkg::word_t     i_instruction;
    logic [PC_W-1:0]   i_pc_next;
    logic              i_wb_we;
    id_pkg::reg_addr_t i_wb_addr;
    id_pkg::word_t     i_wb_data;
    id_pkg::word_t     o_data_a;
    id_pkg::word_t     o_data_b;
    id_pkg::word_t     o_imm_ext;
    id_pkg::reg_addr_t o_rs;
    id_pkg::reg_addr_t o_rt;
    id_pkg::reg_addr_t o_rw;
    id_pkg::branch_e   o_branch;
    logic              o_branch_taken;
    logic [PC_W-1:0]   o_branch_target;
    logic              o_reg_dst;
    logic              o_reg_write;
    logic              o_alu_src;
    id_pkg::alu_op_t   o_alu_op;
    logic              o_mem_read;
    logic              o_mem_write;
    logic              o_mem_to_reg;
    logic [7:0]        ctrl;

    vector_t       vectors [TABLE_LEN];
    id_pkg::word_t model [id_pkg::REG_COUNT];
    integer        seed   = 12;
    int            errors = 0;
    int            checks = 0;
    int            cycles = 0;

    assign ctrl = {o_reg_dst, o_reg_write, o_alu_src, o_alu_op,
                   o_mem_read, o_mem_write, o_mem_to_reg};

    id_stage #(
        .PC_W (PC_W)
    ) id_stage_inst (
        .i_clock         (i_clock),
        .i_rst_n         (i_rst_n),
        .i_instruction   (i_instruction),
        .i_pc_next       (i_pc_next),
        .i_wb_we         (i_wb_we),
        .i_wb_addr       (i_wb_addr),
        .i_wb_data       (i_wb_data),
        .o_data_a        (o_data_a),
        .o_data_b        (o_data_b),
        .o_imm_ext       (o_imm_ext),
        .o_rs            (o_rs),
        .o_rt            (o_rt),
        .o_rw            (o_rw),
        .o_branch        (o_branch),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_reg_dst       (o_reg_dst),
        .o_reg_write     (o_reg_write),
        .o_alu_src       (o_alu_src),
        .o_alu_op        (o_alu_op),
        .o_mem_read      (o_mem_read),
        .o_mem_write     (o_mem_write),
        .o_mem_to_reg    (o_mem_to_reg)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // Watchdog on the total run length.
    always @(posedge i_clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoders and checks.
    ////////////////////////////////////////////////////////////////////////////

    function automatic id_pkg::word_t encode_r(input id_pkg::reg_addr_t rs,
                                               input id_pkg::reg_addr_t rt,
                                               input id_pkg::reg_addr_t rd,
                                               input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic id_pkg::word_t encode_i(input logic [5:0] op,
                                               input id_pkg::reg_addr_t rs,
                                               input id_pkg::reg_addr_t rt,
                                               input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic id_pkg::word_t encode_j(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic load_vectors();
        vectors[0]  = '{encode_r(5'd1, 5'd2, 5'd3, 6'h20), 11'd100,
                        id_pkg::BR_NONE, 1'b0, CTRL_RTYPE, 5'd3};
        vectors[1]  = '{encode_r(5'd0, 5'd0, 5'd0, 6'h00), 11'd101,
                        id_pkg::BR_NONE, 1'b0, CTRL_RTYPE, 5'd0};
        vectors[2]  = '{encode_r(5'd4, 5'd0, 5'd0, id_pkg::FUNCT_JR), 11'd200,
                        id_pkg::BR_JR, 1'b1, CTRL_JR, 5'd0};
        vectors[3]  = '{encode_r(5'd5, 5'd0, 5'd29, id_pkg::FUNCT_JALR), 11'd201,
                        id_pkg::BR_JALR, 1'b1, CTRL_RTYPE, 5'd29};
        vectors[4]  = '{encode_j(id_pkg::OP_J, 26'h0C00F5A), 11'd202,
                        id_pkg::BR_J, 1'b1, CTRL_NONE, 5'd0};
        vectors[5]  = '{encode_j(id_pkg::OP_JAL, 26'h0030ABC), 11'd203,
                        id_pkg::BR_JAL, 1'b1, CTRL_JAL, 5'd31};
        // Conditional branches with wrapping targets.
        vectors[6]  = '{encode_i(id_pkg::OP_BEQ, 5'd5, 5'd5, 16'h0008), 11'd300,
                        id_pkg::BR_BEQ, 1'b1, CTRL_BR, 5'd5};
        vectors[7]  = '{encode_i(id_pkg::OP_BEQ, 5'd5, 5'd6, 16'hFFFC), 11'd300,
                        id_pkg::BR_BEQ, 1'b0, CTRL_BR, 5'd6};
        vectors[8]  = '{encode_i(id_pkg::OP_BNE, 5'd7, 5'd8, 16'hFFEC), 11'd10,
                        id_pkg::BR_BNE, 1'b1, CTRL_BR, 5'd8};
        vectors[9]  = '{encode_i(id_pkg::OP_BNE, 5'd9, 5'd9, 16'h0040), 11'd2040,
                        id_pkg::BR_BNE, 1'b0, CTRL_BR, 5'd9};
        vectors[10] = '{encode_i(id_pkg::OP_BEQ, 5'd0, 5'd0, 16'h7FFF), 11'd5,
                        id_pkg::BR_BEQ, 1'b1, CTRL_BR, 5'd0};
        // Immediate forms and memory.
        vectors[11] = '{encode_i(id_pkg::OP_ADDI, 5'd11, 5'd10, 16'h8000), 11'd400,
                        id_pkg::BR_NONE, 1'b0, CTRL_IMM, 5'd10};
        vectors[12] = '{encode_i(id_pkg::OP_SLTI, 5'd12, 5'd13, 16'h7FFF), 11'd401,
                        id_pkg::BR_NONE, 1'b0, CTRL_IMM, 5'd13};
        vectors[13] = '{encode_i(id_pkg::OP_ANDI, 5'd14, 5'd15, 16'hF0F0), 11'd402,
                        id_pkg::BR_NONE, 1'b0, CTRL_IMM, 5'd15};
        vectors[14] = '{encode_i(id_pkg::OP_ORI, 5'd16, 5'd17, 16'h0F0F), 11'd403,
                        id_pkg::BR_NONE, 1'b0, CTRL_IMM, 5'd17};
        vectors[15] = '{encode_i(id_pkg::OP_LUI, 5'd0, 5'd18, 16'hABCD), 11'd404,
                        id_pkg::BR_NONE, 1'b0, CTRL_IMM, 5'd18};
        vectors[16] = '{encode_i(id_pkg::OP_LW, 5'd19, 5'd20, 16'hFFF8), 11'd405,
                        id_pkg::BR_NONE, 1'b0, CTRL_LW, 5'd20};
        vectors[17] = '{encode_i(id_pkg::OP_SW, 5'd21, 5'd22, 16'h0010), 11'd406,
                        id_pkg::BR_NONE, 1'b0, CTRL_SW, 5'd22};
        vectors[18] = '{encode_i(6'h3F, 5'd23, 5'd24, 16'h1234), 11'd407,
                        id_pkg::BR_NONE, 1'b0, CTRL_NONE, 5'd24};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test phases.
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        for (int k = 0; k < id_pkg::REG_COUNT; k++) begin
            @(negedge i_clock);
            i_instruction = encode_r(id_pkg::reg_addr_t'(k),
                                     id_pkg::reg_addr_t'(id_pkg::REG_COUNT - 1 - k), 5'd0, 6'h20);
            #SETTLE;
            check_value($sformatf("reset read r%0d on port A", k), o_data_a, 32'd0);
            check_value($sformatf("reset read r%0d on port B", id_pkg::REG_COUNT - 1 - k),
                        o_data_b, 32'd0);
        end
        // All-zero instruction is a plain R-type.
        @(negedge i_clock);
        i_instruction = '0;
        #SETTLE;
        check_value("reset control outputs", ctrl, CTRL_RTYPE);
        check_value("reset taken flag", o_branch_taken, 1'b0);
    endtask

    task automatic preload_registers();
        id_pkg::word_t value;
        for (int k = 1; k < id_pkg::REG_COUNT; k++) begin
            value = $random(seed);
            @(negedge i_clock);
            i_instruction = encode_r(id_pkg::reg_addr_t'(k), id_pkg::reg_addr_t'(k), 5'd0, 6'h20);
            i_wb_we       = 1'b1;
            i_wb_addr     = id_pkg::reg_addr_t'(k);
            i_wb_data     = value;
            #SETTLE;
            // Without bypass the old value is still seen.
            check_value($sformatf("r%0d before write", k), o_data_a, model[k]);
            model[k] = value;
            @(negedge i_clock);
            i_wb_we = 1'b0;
            #SETTLE;
            check_value($sformatf("r%0d on port A", k), o_data_a, model[k]);
            check_value($sformatf("r%0d on port B", k), o_data_b, model[k]);
        end
        @(negedge i_clock);
        i_instruction = '0;
        i_wb_we       = 1'b1;
        i_wb_addr     = '0;
        i_wb_data     = 32'hDEADBEEF;
        @(negedge i_clock);
        i_wb_we = 1'b0;
        #SETTLE;
        check_value("r0 after write on port A", o_data_a, 32'd0);
        check_value("r0 after write on port B", o_data_b, 32'd0);
    endtask

    task automatic check_vector(input int n);
        vector_t           v;
        id_pkg::reg_addr_t rs;
        id_pkg::reg_addr_t rt;
        id_pkg::word_t     exp_a;
        id_pkg::word_t     exp_b;
        id_pkg::word_t     exp_imm;
        logic [PC_W-1:0]   exp_target;
        v       = vectors[n];
        rs      = v.instr[25:21];
        rt      = v.instr[20:16];
        exp_a   = model[rs];
        exp_b   = model[rt];
        exp_imm = {{16{v.instr[15]}}, v.instr[15:0]};
        case (v.branch)
            id_pkg::BR_BEQ, id_pkg::BR_BNE: exp_target = v.pc_next + exp_imm[PC_W-1:0];
            id_pkg::BR_J, id_pkg::BR_JAL:   exp_target = v.instr[PC_W-1:0];
            id_pkg::BR_JR, id_pkg::BR_JALR: exp_target = exp_a[PC_W-1:0];
            default:                        exp_target = v.pc_next;
        endcase
        check_value($sformatf("vector %0d o_rs", n), o_rs, rs);
        check_value($sformatf("vector %0d o_rt", n), o_rt, rt);
        check_value($sformatf("vector %0d o_rw", n), o_rw, v.rw);
        check_value($sformatf("vector %0d o_data_a", n), o_data_a, exp_a);
        check_value($sformatf("vector %0d o_data_b", n), o_data_b, exp_b);
        check_value($sformatf("vector %0d o_imm_ext", n), o_imm_ext, exp_imm);
        check_value($sformatf("vector %0d o_branch", n), o_branch, v.branch);
        check_value($sformatf("vector %0d taken flag", n), o_branch_taken, v.taken);
        check_value($sformatf("vector %0d target", n), o_branch_target, exp_target);
        check_value($sformatf("vector %0d control outputs", n), ctrl, v.ctrl);
    endtask

    initial begin
        i_clock       = 1'b0;
        i_rst_n       = 1'b0;
        i_instruction = '0;
        i_pc_next     = '0;
        i_wb_we       = 1'b0;
        i_wb_addr     = '0;
        i_wb_data     = '0;
        for (int k = 0; k < id_pkg::REG_COUNT; k++) begin
            model[k] = '0;
        end
        load_vectors();

        repeat (RESET_CYCLES) @(posedge i_clock);
        @(negedge i_clock);
        i_rst_n = 1'b1;

        check_reset_state();
        preload_registers();

        // Decode table.
        for (int n = 0; n < TABLE_LEN; n++) begin
            @(negedge i_clock);
            i_instruction = vectors[n].instr;
            i_pc_next     = vectors[n].pc_next;
            #SETTLE;
            check_vector(n);
        end

        @(negedge i_clock);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_control.sv
rtl/id_register_file.sv
rtl/id_branch_unit.sv
rtl/id_stage.sv
verification/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

dependencies: {}

sources:
  # Design sources in compile order.
  - files:
      - rtl/id_pkg.sv
      - rtl/id_decoder.sv
      - rtl/id_control.sv
      - rtl/id_register_file.sv
      - rtl/id_branch_unit.sv
      - rtl/id_stage.sv
  # Testbench.
  - target: test
    files:
      - verification/tb_id_stage.sv
